// ==== source/mhq_pkg.sv ====
// Miss path shared definitions
// Widths, depths, the cache line union and the structs passed between
// the miss queue, the CCU and the fill store

package mhq_pkg;

    // Address and line geometry
    localparam int ADDR_WIDTH        = 10;
    localparam int WORD_SIZE         = 4;
    localparam int LINE_SIZE         = 16;
    localparam int OFFSET_WIDTH      = 4;
    localparam int LINE_ADDR_WIDTH   = 6;
    localparam int BYTE_OFFSET_WIDTH = 2;
    localparam int WORD_SEL_WIDTH    = OFFSET_WIDTH - BYTE_OFFSET_WIDTH;
    localparam int WORDS_PER_LINE    = LINE_SIZE / WORD_SIZE;

    // Miss queue
    localparam int MHQ_DEPTH     = 4;
    localparam int MHQ_TAG_WIDTH = 2;

    // Backing memory with one word per entry
    localparam int MEM_LATENCY   = 6;
    localparam int LAT_CNT_WIDTH = 3;
    localparam int MEM_WORDS     = 2 ** (ADDR_WIDTH - BYTE_OFFSET_WIDTH);

    // Direct-mapped fill store
    localparam int FILL_SETS        = 8;
    localparam int FILL_INDEX_WIDTH = 3;
    localparam int FILL_TAG_WIDTH   = LINE_ADDR_WIDTH - FILL_INDEX_WIDTH;

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [MHQ_TAG_WIDTH-1:0]   mhq_tag_t;
    typedef logic [8*WORD_SIZE-1:0]     word_t;
    typedef logic [WORD_SIZE-1:0]       byte_sel_t;
    typedef logic [LINE_SIZE-1:0]       line_mask_t;

    // Byte view for merging, word view for the read port
    typedef union packed {
        logic [LINE_SIZE-1:0][7:0]  bytes;
        word_t [WORDS_PER_LINE-1:0] words;
    } cacheline_u;

    typedef struct packed {
        logic      en;
        logic      we;
        addr_t     addr;
        word_t     data;
        byte_sel_t byte_sel;
    } mhq_enq_t;

    typedef struct packed {
        logic       valid;
        mhq_tag_t   tag;
        line_addr_t line_addr;
        logic       dirty;
        cacheline_u store_data;
        line_mask_t store_mask;
    } mhq_fill_t;

    typedef struct packed {
        logic       done;
        line_addr_t line_addr;
        cacheline_u data;
    } ccu_resp_t;

endpackage

// ==== source/miss_handling_queue.sv ====
// Miss handling queue
// Allocates an entry per missing line, merges later loads and stores to
// the same line, and retires the head entry when the CCU returns its line

`timescale 1ns/1ps

module miss_handling_queue (
    input  logic                clk,
    input  logic                n_rst,

    input  mhq_pkg::mhq_enq_t   i_enq,
    output mhq_pkg::mhq_tag_t   o_enq_tag,
    output logic                o_mhq_full,

    input  mhq_pkg::ccu_resp_t  i_ccu_resp,
    output logic                o_ccu_en,
    output mhq_pkg::line_addr_t o_ccu_addr,

    output mhq_pkg::mhq_fill_t  o_fill
);

    typedef struct packed {
        logic                dirty;
        mhq_pkg::line_addr_t line_addr;
        mhq_pkg::cacheline_u store_data;
        mhq_pkg::line_mask_t store_mask;
    } mhq_entry_t;

    mhq_entry_t                       entries [mhq_pkg::MHQ_DEPTH];
    logic [mhq_pkg::MHQ_DEPTH-1:0]    entry_valid;

    // Extra top bit tells a full queue from an empty one
    logic [mhq_pkg::MHQ_TAG_WIDTH:0]  head_ptr;
    logic [mhq_pkg::MHQ_TAG_WIDTH:0]  tail_ptr;
    mhq_pkg::mhq_tag_t                head_idx;
    mhq_pkg::mhq_tag_t                tail_idx;
    logic                             mhq_full;

    mhq_pkg::line_addr_t              enq_line_addr;
    logic [mhq_pkg::OFFSET_WIDTH-1:0] enq_offset;
    mhq_pkg::line_mask_t              enq_store_mask;
    mhq_pkg::cacheline_u              enq_line;
    logic [mhq_pkg::MHQ_DEPTH-1:0]    merge_sel;
    mhq_pkg::mhq_tag_t                merge_tag;
    mhq_pkg::mhq_tag_t                enq_tag;
    logic                             merge_hit;
    logic                             merging;
    logic                             allocating;
    logic                             filling;

    assign head_idx = head_ptr[mhq_pkg::MHQ_TAG_WIDTH-1:0];
    assign tail_idx = tail_ptr[mhq_pkg::MHQ_TAG_WIDTH-1:0];
    assign mhq_full = (head_ptr[mhq_pkg::MHQ_TAG_WIDTH] != tail_ptr[mhq_pkg::MHQ_TAG_WIDTH])
                      && (head_idx == tail_idx);

    assign filling = i_ccu_resp.done;

    assign enq_line_addr = i_enq.addr[mhq_pkg::ADDR_WIDTH-1:mhq_pkg::OFFSET_WIDTH];
    assign enq_offset    = i_enq.addr[mhq_pkg::OFFSET_WIDTH-1:0];

    // Store bytes move to their offset in the line and loads set no mask bits
    always_comb begin
        enq_store_mask = '0;
        if (i_enq.we) begin
            enq_store_mask = {{(mhq_pkg::LINE_SIZE-mhq_pkg::WORD_SIZE){1'b0}}, i_enq.byte_sel}
                             << enq_offset;
        end
        enq_line = {{(8*(mhq_pkg::LINE_SIZE-mhq_pkg::WORD_SIZE)){1'b0}}, i_enq.data}
                   << {enq_offset, 3'b000};
    end

    // Head entry being retired this cycle is not a merge target
    always_comb begin
        merge_tag = '0;
        for (int i = 0; i < mhq_pkg::MHQ_DEPTH; i++) begin
            merge_sel[i] = entry_valid[i] && (entries[i].line_addr == enq_line_addr)
                           && !(filling && (head_idx == mhq_pkg::mhq_tag_t'(i)));
            if (merge_sel[i]) begin
                merge_tag = mhq_pkg::mhq_tag_t'(i);
            end
        end
    end

    assign merge_hit  = |merge_sel;
    assign merging    = i_enq.en && merge_hit;
    assign allocating = i_enq.en && !merge_hit && !mhq_full;
    assign enq_tag    = merge_hit ? merge_tag : tail_idx;

    assign o_enq_tag  = enq_tag;
    assign o_mhq_full = mhq_full;

    // Fetch request for the oldest waiting line
    assign o_ccu_en   = entry_valid[head_idx];
    assign o_ccu_addr = entries[head_idx].line_addr;

    always_comb begin
        o_fill.valid      = filling;
        o_fill.tag        = head_idx;
        o_fill.line_addr  = entries[head_idx].line_addr;
        o_fill.dirty      = entries[head_idx].dirty;
        o_fill.store_data = entries[head_idx].store_data;
        o_fill.store_mask = entries[head_idx].store_mask;
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            entry_valid <= '0;
        end else begin
            if (filling) begin
                entry_valid[head_idx] <= 1'b0;
            end
            if (allocating) begin
                entry_valid[tail_idx] <= 1'b1;
            end
        end
    end

    // A store keeps the entry dirty until it retires
    always_ff @(posedge clk) begin
        if (allocating) begin
            entries[tail_idx].line_addr  <= enq_line_addr;
            entries[tail_idx].dirty      <= i_enq.we;
            entries[tail_idx].store_mask <= enq_store_mask;
        end else if (merging) begin
            entries[merge_tag].dirty      <= entries[merge_tag].dirty | i_enq.we;
            entries[merge_tag].store_mask <= entries[merge_tag].store_mask | enq_store_mask;
        end
        if (merging || allocating) begin
            for (int j = 0; j < mhq_pkg::LINE_SIZE; j++) begin
                if (enq_store_mask[j]) begin
                    entries[enq_tag].store_data.bytes[j] <= enq_line.bytes[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (filling) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (allocating) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    // Source may only strobe waiting lines while the queue is full
    a_no_new_line_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_enq.en && !merge_hit && mhq_full));

    // CCU only completes a fetch that the head entry asked for
    a_fill_needs_valid_head: assert property (@(posedge clk) disable iff (!n_rst)
        filling |-> entry_valid[head_idx]);

endmodule

// ==== source/ccu_line_fetch.sv ====
// Cache control unit line fetch
// Backing memory preloaded one word at a time; returns the requested line
// a fixed number of cycles after the request is captured

`timescale 1ns/1ps

module ccu_line_fetch (
    input  logic                clk,
    input  logic                n_rst,

    input  logic                i_ccu_en,
    input  mhq_pkg::line_addr_t i_ccu_addr,

    input  logic                i_mem_wr_en,
    input  mhq_pkg::addr_t      i_mem_wr_addr,
    input  mhq_pkg::word_t      i_mem_wr_data,

    output mhq_pkg::ccu_resp_t  o_resp
);

    mhq_pkg::word_t                    mem [mhq_pkg::MEM_WORDS];

    logic                              busy;
    logic                              done_q;
    logic                              idle;
    logic                              fetch_last;
    logic [mhq_pkg::LAT_CNT_WIDTH-1:0] lat_cnt;
    mhq_pkg::line_addr_t               cap_addr;
    mhq_pkg::cacheline_u               resp_line;

    // Preload port reduces the byte address to a word index
    always_ff @(posedge clk) begin
        if (i_mem_wr_en) begin
            mem[i_mem_wr_addr[mhq_pkg::ADDR_WIDTH-1:mhq_pkg::BYTE_OFFSET_WIDTH]] <= i_mem_wr_data;
        end
    end

    // The done cycle itself does not sample, so the retired head is never refetched
    assign idle       = !busy && !done_q;
    assign fetch_last = busy && (lat_cnt == mhq_pkg::LAT_CNT_WIDTH'(mhq_pkg::MEM_LATENCY - 1));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy    <= 1'b0;
            done_q  <= 1'b0;
            lat_cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (idle && i_ccu_en) begin
                busy    <= 1'b1;
                lat_cnt <= '0;
            end else if (fetch_last) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
            end else if (busy) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && i_ccu_en) begin
            cap_addr <= i_ccu_addr;
        end
        if (fetch_last) begin
            for (int w = 0; w < mhq_pkg::WORDS_PER_LINE; w++) begin
                resp_line.words[w] <= mem[{cap_addr, mhq_pkg::WORD_SEL_WIDTH'(w)}];
            end
        end
    end

    assign o_resp.done      = done_q;
    assign o_resp.line_addr = cap_addr;
    assign o_resp.data      = resp_line;

    // Done only comes MEM_LATENCY cycles after a request was captured while idle
    a_done_after_capture: assert property (@(posedge clk) disable iff (!n_rst)
        o_resp.done |-> $past(idle && i_ccu_en, mhq_pkg::MEM_LATENCY + 1));

endmodule

// ==== source/fill_line_store.sv ====
// Fill line store
// Merges fetched lines with queued store bytes and keeps the result in a
// small direct-mapped store that is read one word at a time

`timescale 1ns/1ps

module fill_line_store (
    input  logic               clk,
    input  logic               n_rst,

    input  mhq_pkg::mhq_fill_t i_fill,
    input  mhq_pkg::ccu_resp_t i_ccu_resp,

    input  mhq_pkg::addr_t     i_rd_addr,
    output logic               o_rd_hit,
    output mhq_pkg::word_t     o_rd_data
);

    typedef struct packed {
        logic                                dirty;
        logic [mhq_pkg::FILL_TAG_WIDTH-1:0]  tag;
        mhq_pkg::cacheline_u                 line;
    } fill_set_t;

    fill_set_t                             sets [mhq_pkg::FILL_SETS];
    logic [mhq_pkg::FILL_SETS-1:0]         set_valid;

    mhq_pkg::cacheline_u                   merged_line;
    logic [mhq_pkg::FILL_INDEX_WIDTH-1:0]  wr_index;
    logic [mhq_pkg::FILL_TAG_WIDTH-1:0]    wr_tag;

    mhq_pkg::line_addr_t                   rd_line_addr;
    logic [mhq_pkg::FILL_INDEX_WIDTH-1:0]  rd_index;
    logic [mhq_pkg::FILL_TAG_WIDTH-1:0]    rd_tag;
    logic [mhq_pkg::WORD_SEL_WIDTH-1:0]    rd_word;

    // Store bytes win over memory bytes
    always_comb begin
        for (int i = 0; i < mhq_pkg::LINE_SIZE; i++) begin
            merged_line.bytes[i] = i_fill.store_mask[i] ? i_fill.store_data.bytes[i]
                                                        : i_ccu_resp.data.bytes[i];
        end
    end

    assign wr_index = i_ccu_resp.line_addr[mhq_pkg::FILL_INDEX_WIDTH-1:0];
    assign wr_tag   = i_ccu_resp.line_addr[mhq_pkg::LINE_ADDR_WIDTH-1:mhq_pkg::FILL_INDEX_WIDTH];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            set_valid <= '0;
        end else if (i_ccu_resp.done) begin
            set_valid[wr_index] <= 1'b1;
        end
    end

    // Whatever held the set before is simply replaced
    always_ff @(posedge clk) begin
        if (i_ccu_resp.done) begin
            sets[wr_index].dirty <= i_fill.dirty;
            sets[wr_index].tag   <= wr_tag;
            sets[wr_index].line  <= merged_line;
        end
    end

    assign rd_line_addr = i_rd_addr[mhq_pkg::ADDR_WIDTH-1:mhq_pkg::OFFSET_WIDTH];
    assign rd_index     = rd_line_addr[mhq_pkg::FILL_INDEX_WIDTH-1:0];
    assign rd_tag       = rd_line_addr[mhq_pkg::LINE_ADDR_WIDTH-1:mhq_pkg::FILL_INDEX_WIDTH];
    assign rd_word      = i_rd_addr[mhq_pkg::OFFSET_WIDTH-1:mhq_pkg::BYTE_OFFSET_WIDTH];

    assign o_rd_hit  = set_valid[rd_index] && (sets[rd_index].tag == rd_tag);
    assign o_rd_data = sets[rd_index].line.words[rd_word];

    // Queue head and CCU must agree on the line being filled
    a_fill_line_matches: assert property (@(posedge clk) disable iff (!n_rst)
        i_fill.valid |-> (i_fill.line_addr == i_ccu_resp.line_addr));

endmodule

// ==== source/dcache_miss_path.sv ====
// Data cache miss path top level
// Connects the miss queue, the CCU line fetch and the fill store

`timescale 1ns/1ps

module dcache_miss_path (
    input  logic                clk,
    input  logic                n_rst,

    input  mhq_pkg::mhq_enq_t   i_enq,
    output mhq_pkg::mhq_tag_t   o_enq_tag,
    output logic                o_mhq_full,

    input  logic                i_mem_wr_en,
    input  mhq_pkg::addr_t      i_mem_wr_addr,
    input  mhq_pkg::word_t      i_mem_wr_data,

    input  mhq_pkg::addr_t      i_rd_addr,
    output logic                o_rd_hit,
    output mhq_pkg::word_t      o_rd_data,

    output logic                o_fill_valid,
    output mhq_pkg::line_addr_t o_fill_addr,
    output logic                o_fill_dirty
);

    logic                ccu_en;
    mhq_pkg::line_addr_t ccu_addr;
    mhq_pkg::ccu_resp_t  ccu_resp;
    mhq_pkg::mhq_fill_t  fill;

    miss_handling_queue u_mhq (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_enq      (i_enq),
        .o_enq_tag  (o_enq_tag),
        .o_mhq_full (o_mhq_full),
        .i_ccu_resp (ccu_resp),
        .o_ccu_en   (ccu_en),
        .o_ccu_addr (ccu_addr),
        .o_fill     (fill)
    );

    ccu_line_fetch u_ccu (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_ccu_en      (ccu_en),
        .i_ccu_addr    (ccu_addr),
        .i_mem_wr_en   (i_mem_wr_en),
        .i_mem_wr_addr (i_mem_wr_addr),
        .i_mem_wr_data (i_mem_wr_data),
        .o_resp        (ccu_resp)
    );

    fill_line_store u_fill (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_fill     (fill),
        .i_ccu_resp (ccu_resp),
        .i_rd_addr  (i_rd_addr),
        .o_rd_hit   (o_rd_hit),
        .o_rd_data  (o_rd_data)
    );

    // Fill status seen from outside
    assign o_fill_valid = fill.valid;
    assign o_fill_addr  = fill.line_addr;
    assign o_fill_dirty = fill.dirty;

endmodule

// ==== tests/tb_dcache_miss_path.sv ====
// Testbench for the data cache miss path
// Directed tests plus a seeded random run, checked against a queue and
// memory reference model kept in the testbench

`timescale 1ns/1ps

module tb_dcache_miss_path;

    localparam int CLK_PERIOD = 40;
    localparam int DEPTH      = mhq_pkg::MHQ_DEPTH;
    localparam int MEM_WORDS  = mhq_pkg::MEM_WORDS;
    localparam int LINES      = 2 ** mhq_pkg::LINE_ADDR_WIDTH;

    // Cycle budgets of the run phases
    localparam int PRELOAD_CYCLES  = MEM_WORDS + 10;
    localparam int DIRECTED_CYCLES = 5 * 80;
    localparam int RANDOM_OPS      = 200;
    localparam int RANDOM_CYCLES   = RANDOM_OPS + 120;
    localparam int MARGIN_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES = PRELOAD_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + MARGIN_CYCLES;
    localparam int WAIT_LIMIT      = 64;

    logic                clk;
    logic                n_rst;
    mhq_pkg::mhq_enq_t   i_enq;
    mhq_pkg::mhq_tag_t   o_enq_tag;
    logic                o_mhq_full;
    logic                i_mem_wr_en;
    mhq_pkg::addr_t      i_mem_wr_addr;
    mhq_pkg::word_t      i_mem_wr_data;
    mhq_pkg::addr_t      i_rd_addr;
    logic                o_rd_hit;
    mhq_pkg::word_t      o_rd_data;
    logic                o_fill_valid;
    mhq_pkg::line_addr_t o_fill_addr;
    logic                o_fill_dirty;

    // Reference model of memory, queue entries and filled lines
    mhq_pkg::word_t      mem_model [MEM_WORDS];
    logic                m_valid [DEPTH];
    logic                m_dirty [DEPTH];
    mhq_pkg::line_addr_t m_line [DEPTH];
    logic [15:0]         m_mask [DEPTH];
    logic [127:0]        m_data [DEPTH];
    int                  m_head;
    int                  m_tail;
    int                  m_count;
    logic [127:0]        exp_line [LINES];
    logic                exp_valid [LINES];
    mhq_pkg::line_addr_t fill_log [$];
    int                  fill_count;
    logic                last_fill_dirty;
    mhq_pkg::mhq_tag_t   last_tag;
    logic                last_full;
    string               cur_test;
    integer              seed = 32'hd7b16217;

    dcache_miss_path uut (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_enq         (i_enq),
        .o_enq_tag     (o_enq_tag),
        .o_mhq_full    (o_mhq_full),
        .i_mem_wr_en   (i_mem_wr_en),
        .i_mem_wr_addr (i_mem_wr_addr),
        .i_mem_wr_data (i_mem_wr_data),
        .i_rd_addr     (i_rd_addr),
        .o_rd_hit      (o_rd_hit),
        .o_rd_data     (o_rd_data),
        .o_fill_valid  (o_fill_valid),
        .o_fill_addr   (o_fill_addr),
        .o_fill_dirty  (o_fill_dirty)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERR %s %s: expected %0h actual %0h",
                                cur_test, what, expected, actual));
        end
    endtask

    // Memory bytes of a line with the queued store bytes laid over them
    function automatic logic [127:0] merged_expect(input mhq_pkg::line_addr_t line,
                                                   input logic [15:0] mask,
                                                   input logic [127:0] data);
        logic [127:0]   result;
        mhq_pkg::word_t w;
        for (int b = 0; b < 16; b++) begin
            w = mem_model[int'(line) * 4 + b / 4];
            result[8*b +: 8] = mask[b] ? data[8*b +: 8] : w[8*(b%4) +: 8];
        end
        return result;
    endfunction

    // A new line may only be strobed when the queue has room
    function automatic logic can_enqueue(input mhq_pkg::line_addr_t line);
        logic ok;
        ok = (m_count < DEPTH);
        for (int i = 0; i < DEPTH; i++) begin
            if (m_valid[i] && m_line[i] == line && !(o_fill_valid && i == m_head)) begin
                ok = 1'b1;
            end
        end
        return ok;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
    endtask

    task automatic reset_dut();
        n_rst  = 1'b0;
        i_enq  = '0;
        repeat (3) @(posedge clk);
        #2;
        n_rst = 1'b1;
        clear_model();
    endtask

    task automatic preload_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = $random(seed);
            @(posedge clk);
            #2;
            i_mem_wr_en   = 1'b1;
            i_mem_wr_addr = mhq_pkg::addr_t'(i * 4);
            i_mem_wr_data = mem_model[i];
        end
        @(posedge clk);
        #2;
        i_mem_wr_en = 1'b0;
    endtask

    task automatic retire_head();
        if (m_count == 0) begin
            abort_run($sformatf("%s: a fill was reported with no line waiting", cur_test));
        end else begin
            check_value("o_fill_addr", m_line[m_head], o_fill_addr);
            check_value("o_fill_dirty", m_dirty[m_head], o_fill_dirty);
            exp_line[m_line[m_head]]  = merged_expect(m_line[m_head], m_mask[m_head],
                                                      m_data[m_head]);
            exp_valid[m_line[m_head]] = 1'b1;
            fill_log.push_back(o_fill_addr);
            last_fill_dirty  = o_fill_dirty;
            fill_count       = fill_count + 1;
            m_valid[m_head]  = 1'b0;
            m_head           = (m_head + 1) % DEPTH;
            m_count          = m_count - 1;
        end
    endtask

    // Sample at the falling edge, retire first so a fill cycle never merges into the head
    task automatic observe(input logic en, input logic we, input mhq_pkg::addr_t addr,
                           input mhq_pkg::word_t data, input mhq_pkg::byte_sel_t sel);
        logic                full_now;
        logic                hit;
        int                  idx;
        int                  off;
        mhq_pkg::line_addr_t line;
        @(negedge clk);
        full_now = (m_count == DEPTH);
        check_value("o_mhq_full", full_now, o_mhq_full);
        if (o_fill_valid) begin
            retire_head();
        end
        if (en) begin
            line = addr[9:4];
            off  = int'(addr[3:0]);
            hit  = 1'b0;
            idx  = 0;
            for (int i = 0; i < DEPTH; i++) begin
                if (m_valid[i] && m_line[i] == line) begin
                    hit = 1'b1;
                    idx = i;
                end
            end
            if (!hit && full_now) begin
                abort_run($sformatf("%s: a new line was strobed while the queue was full",
                                    cur_test));
            end else begin
                if (!hit) begin
                    idx          = m_tail;
                    m_valid[idx] = 1'b1;
                    m_line[idx]  = line;
                    m_dirty[idx] = 1'b0;
                    m_mask[idx]  = '0;
                    m_data[idx]  = '0;
                    m_tail       = (m_tail + 1) % DEPTH;
                    m_count      = m_count + 1;
                end
                check_value("o_enq_tag", idx, o_enq_tag);
                if (we) begin
                    m_dirty[idx] = 1'b1;
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b] && off + b < 16) begin
                            m_mask[idx][off+b]         = 1'b1;
                            m_data[idx][8*(off+b) +: 8] = data[8*b +: 8];
                        end
                    end
                end
            end
        end
    endtask

    task automatic drive_cycle(input logic en, input logic we, input mhq_pkg::addr_t addr,
                               input mhq_pkg::word_t data, input mhq_pkg::byte_sel_t sel,
                               input logic guarded);
        logic strobe;
        @(posedge clk);
        #2;
        strobe         = en && (!guarded || can_enqueue(addr[9:4]));
        i_enq.en       = strobe;
        i_enq.we       = we;
        i_enq.addr     = addr;
        i_enq.data     = data;
        i_enq.byte_sel = sel;
        observe(strobe, we, addr, data, sel);
        last_tag  = o_enq_tag;
        last_full = o_mhq_full;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0);
    endtask

    task automatic wait_fills(input int target);
        int n;
        n = 0;
        while (fill_count < target) begin
            if (n >= WAIT_LIMIT) begin
                abort_run($sformatf("%s: expected fill did not arrive", cur_test));
            end else begin
                idle_cycle();
                n = n + 1;
            end
        end
    endtask

    task automatic wait_queue_empty();
        wait_fills(fill_count + m_count);
    endtask

    task automatic read_word(input mhq_pkg::addr_t addr, output logic hit,
                             output mhq_pkg::word_t data);
        @(posedge clk);
        #2;
        i_enq.en  = 1'b0;
        i_rd_addr = addr;
        observe(1'b0, 1'b0, '0, '0, '0);
        hit  = o_rd_hit;
        data = o_rd_data;
    endtask

    task automatic check_line(input mhq_pkg::line_addr_t line);
        logic           hit;
        mhq_pkg::word_t data;
        for (int w = 0; w < 4; w++) begin
            read_word(mhq_pkg::addr_t'(int'(line) * 16 + w * 4), hit, data);
            if (!hit) begin
                abort_run($sformatf("%s: read of line %0h word %0d missed in the fill store",
                                    cur_test, line, w));
            end else begin
                check_value($sformatf("line %0h word %0d", line, w),
                            exp_line[line][32*w +: 32], data);
            end
        end
    endtask

    task automatic test_load_miss();
        cur_test = "load_miss";
        drive_cycle(1'b1, 1'b0, 10'h058, '0, '0, 1'b0);
        wait_fills(fill_count + 1);
        check_value("fill line", 6'd5, fill_log[$]);
        check_value("fill dirty", 1'b0, last_fill_dirty);
        check_line(6'd5);
    endtask

    task automatic test_store_miss();
        cur_test = "store_miss";
        drive_cycle(1'b1, 1'b1, 10'h064, 32'ha5b6c7d8, 4'b0110, 1'b0);
        wait_fills(fill_count + 1);
        check_value("fill line", 6'd6, fill_log[$]);
        check_value("fill dirty", 1'b1, last_fill_dirty);
        check_line(6'd6);
    endtask

    // Load then two stores overlapping on bytes 10 and 11
    task automatic test_merging();
        mhq_pkg::mhq_tag_t first_tag;
        int                fills_before;
        cur_test     = "merging";
        fills_before = fill_count;
        drive_cycle(1'b1, 1'b0, 10'h070, '0, '0, 1'b0);
        first_tag = last_tag;
        drive_cycle(1'b1, 1'b1, 10'h078, 32'h11223344, 4'b1111, 1'b0);
        check_value("second tag", first_tag, last_tag);
        drive_cycle(1'b1, 1'b1, 10'h07a, 32'h0000aabb, 4'b0011, 1'b0);
        check_value("third tag", first_tag, last_tag);
        wait_queue_empty();
        check_value("fill count", fills_before + 1, fill_count);
        check_line(6'd7);
    endtask

    task automatic test_order_and_tags();
        int log_start;
        cur_test = "order_and_tags";
        reset_dut();
        log_start = fill_log.size();
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, 1'b0, mhq_pkg::addr_t'((16 + i) * 16), '0, '0, 1'b0);
            check_value("tag", i, last_tag);
        end
        wait_fills(fill_count + 1);
        drive_cycle(1'b1, 1'b0, mhq_pkg::addr_t'(20 * 16), '0, '0, 1'b0);
        check_value("wrapped tag", 0, last_tag);
        wait_queue_empty();
        for (int i = 0; i < 5; i++) begin
            check_value("fill order", 16 + i, fill_log[log_start+i]);
        end
    endtask

    task automatic test_full_queue();
        mhq_pkg::mhq_tag_t line_tag;
        cur_test = "full_queue";
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, 1'b0, mhq_pkg::addr_t'((24 + i) * 16), '0, '0, 1'b0);
            if (i == 1) begin
                line_tag = last_tag;
            end
        end
        drive_cycle(1'b1, 1'b1, mhq_pkg::addr_t'(25 * 16 + 12), 32'hcafef00d, 4'b1111, 1'b0);
        check_value("full while waiting", 1'b1, last_full);
        check_value("merged tag", line_tag, last_tag);
        wait_fills(fill_count + 1);
        idle_cycle();
        check_value("full after fill", 1'b0, last_full);
        wait_queue_empty();
        check_line(6'd25);
    endtask

    // Six lines on distinct sets so no random fill evicts another
    task automatic test_random();
        integer r;
        integer d;
        int     line;
        cur_test = "random";
        for (int l = 40; l < 46; l++) begin
            exp_valid[l] = 1'b0;
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = $random(seed);
            d    = $random(seed);
            line = 40 + int'(r[10:3]) % 6;
            drive_cycle(r[1:0] != 2'b00, r[2], mhq_pkg::addr_t'(line * 16 + int'(r[14:11])),
                        d, r[18:15], 1'b1);
        end
        wait_queue_empty();
        for (int l = 40; l < 46; l++) begin
            if (exp_valid[l]) begin
                check_line(mhq_pkg::line_addr_t'(l));
            end
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before the tests completed");
    end

    initial begin
        n_rst         = 1'b0;
        i_enq         = '0;
        i_mem_wr_en   = 1'b0;
        i_mem_wr_addr = '0;
        i_mem_wr_data = '0;
        i_rd_addr     = '0;
        fill_count    = 0;
        cur_test      = "setup";
        for (int l = 0; l < LINES; l++) begin
            exp_valid[l] = 1'b0;
        end
        reset_dut();
        preload_memory();
        test_load_miss();
        test_store_miss();
        test_merging();
        test_order_and_tags();
        test_full_queue();
        test_random();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== all.f ====
source/mhq_pkg.sv
source/miss_handling_queue.sv
source/ccu_line_fetch.sv
source/fill_line_store.sv
source/dcache_miss_path.sv
tests/tb_dcache_miss_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the miss path simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache_miss_path -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
